// ==== verilog/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ------------------------------
// Core-wide constants
// ------------------------------

// Data and address width
`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural integer registers
`define RV_NREGS 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {A_RS1, A_ZERO, A_PC} alu_a_src_e;

  // Writeback source
  typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4} res_src_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

  // ------------------------------
  // Decoded control word
  // ------------------------------
  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    alu_a_src_e alu_a_src;
    logic       alu_b_imm;
    alu_op_e    alu_op;
    res_src_e   res_src;
    logic       is_branch;
    logic       is_jump;
    logic       jalr;
    logic [2:0] funct3;
    logic       ebreak;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/rv_dec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

// Decoder outputs, all combinational from the current instruction
interface rv_dec_if import rv_pkg::*; ();
  ctrl_t                ctrl;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  logic [`RV_XLEN-1:0]  imm;

  modport producer (output ctrl, rs1, rs2, rd, imm);
  modport consumer (input ctrl, imm);
  modport regs (input rs1, rs2, rd);
endinterface

`default_nettype wire

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_fetch (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                redirect,
  input  logic [`RV_XLEN-1:0] target,
  input  logic                halt,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4
);

  assign pc_plus4 = pc + `RV_XLEN'd4;

  // Redirect wins over halt, EBREAK never redirects anyway
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else if (redirect) begin
      pc <= target;
    end else if (!halt) begin
      pc <= pc_plus4;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] instr,
  rv_dec_if.producer          dec
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                funct7_b5;
  imm_fmt_e            imm_fmt;
  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  // Shared by register and immediate forms, alt selects SUB or SRA
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ------------------------------
  // Field extraction
  // ------------------------------
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  assign dec.rd  = instr[11:7];
  assign dec.rs1 = instr[19:15];
  assign dec.rs2 = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (imm_fmt)
      IMM_S:   dec.imm = imm_s;
      IMM_B:   dec.imm = imm_b;
      IMM_U:   dec.imm = imm_u;
      IMM_J:   dec.imm = imm_j;
      default: dec.imm = imm_i;
    endcase
  end

  // ------------------------------
  // Control generation
  // ------------------------------
  always_comb begin
    ctrl           = '0;
    ctrl.alu_a_src = A_RS1;
    ctrl.alu_op    = ALU_ADD;
    ctrl.res_src   = RES_ALU;
    ctrl.funct3    = funct3;
    imm_fmt        = IMM_I;

    case (opcode)
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = A_ZERO;
        ctrl.alu_b_imm = 1'b1;
        imm_fmt        = IMM_U;
      end
      OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = A_PC;
        ctrl.alu_b_imm = 1'b1;
        imm_fmt        = IMM_U;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.res_src   = RES_PC4;
        imm_fmt        = IMM_J;
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.res_src   = RES_PC4;
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm_fmt        = IMM_B;
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.res_src   = RES_LOAD;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        imm_fmt        = IMM_S;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        // Bit 30 is immediate data except on SRAI
        ctrl.alu_op    = alu_sel(funct3, funct7_b5 && (funct3 == 3'b101));
      end
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_sel(funct3, funct7_b5);
      end
      OP_SYSTEM: begin
        ctrl.ebreak = (instr[31:7] == {12'h001, 5'd0, 3'd0, 5'd0});
      end
      default: begin
        // Unknown opcode, leave as NOP
      end
    endcase
  end

  assign dec.ctrl = ctrl;

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                arst_n,
  rv_dec_if.regs              dec,
  input  logic                we,
  input  logic [`RV_XLEN-1:0] wdata,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (dec.rd != 5'd0)) begin
      regs[dec.rd] <= wdata;
    end
  end

  // x0 hardwired
  assign rs1_data = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

`default_nettype wire

// ==== verilog/rv_mem_fmt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_mem_fmt (
  input  logic [2:0]          funct3,
  input  logic [1:0]          addr_lo,
  input  logic                mem_write,
  input  logic [`RV_XLEN-1:0] store_data,
  output logic [`RV_XLEN-1:0] wdata,
  output logic [3:0]          wstrb,
  input  logic [`RV_XLEN-1:0] rdata_raw,
  output logic [`RV_XLEN-1:0] load_data
);

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  // Store side, data copied to every lane and strobes pick the target
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        wdata = {4{store_data[7:0]}};
        wstrb = 4'b0001 << addr_lo;
      end
      2'b01: begin
        wdata = {2{store_data[15:0]}};
        wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = store_data;
        wstrb = 4'b1111;
      end
    endcase
    if (!mem_write) begin
      wstrb = 4'b0000;
    end
  end

  // Load side
  assign byte_lane = rdata_raw[8*addr_lo +: 8];
  assign half_lane = addr_lo[1] ? rdata_raw[31:16] : rdata_raw[15:0];

  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{byte_lane[7]}}, byte_lane};
      3'b001:  load_data = {{16{half_lane[15]}}, half_lane};
      3'b100:  load_data = {24'b0, byte_lane};
      3'b101:  load_data = {16'b0, half_lane};
      default: load_data = rdata_raw;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute import rv_pkg::*; (
  rv_dec_if.consumer          dec,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] pc_plus4,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                redirect,
  output logic [`RV_XLEN-1:0] target,
  output logic                rd_we,
  output logic [`RV_XLEN-1:0] rd_data,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [3:0]          dmem_wstrb,
  output logic                dmem_we
);

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [4:0]          shamt;
  logic [`RV_XLEN-1:0] alu_result;
  logic                taken;
  logic [`RV_XLEN-1:0] load_data;

  // ------------------------------
  // ALU
  // ------------------------------
  always_comb begin
    case (dec.ctrl.alu_a_src)
      A_ZERO:  alu_a = '0;
      A_PC:    alu_a = pc;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = dec.ctrl.alu_b_imm ? dec.imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (dec.ctrl.alu_op)
      ALU_ADD:  alu_result = alu_a + alu_b;
      ALU_SUB:  alu_result = alu_a - alu_b;
      ALU_SLL:  alu_result = alu_a << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_result = {31'b0, alu_a < alu_b};
      ALU_XOR:  alu_result = alu_a ^ alu_b;
      ALU_SRL:  alu_result = alu_a >> shamt;
      ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
      ALU_OR:   alu_result = alu_a | alu_b;
      ALU_AND:  alu_result = alu_a & alu_b;
      default:  alu_result = '0;
    endcase
  end

  // ------------------------------
  // Branch and jump
  // ------------------------------
  always_comb begin
    case (dec.ctrl.funct3)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  // JALR goes through the ALU as rs1 + imm
  assign target   = dec.ctrl.jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc + dec.imm;
  assign redirect = dec.ctrl.is_jump | (dec.ctrl.is_branch & taken);

  // ------------------------------
  // Memory access and writeback
  // ------------------------------
  assign dmem_addr = alu_result;
  assign dmem_we   = dec.ctrl.mem_write;

  rv_mem_fmt mem_fmt0 (
    .funct3     (dec.ctrl.funct3),
    .addr_lo    (alu_result[1:0]),
    .mem_write  (dec.ctrl.mem_write),
    .store_data (rs2_data),
    .wdata      (dmem_wdata),
    .wstrb      (dmem_wstrb),
    .rdata_raw  (dmem_rdata),
    .load_data  (load_data)
  );

  assign rd_we = dec.ctrl.reg_write;

  always_comb begin
    case (dec.ctrl.res_src)
      RES_LOAD: rd_data = load_data;
      RES_PC4:  rd_data = pc_plus4;
      default:  rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core (
  input  logic                clk,
  input  logic                arst_n,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] imem_data,
  output logic [`RV_XLEN-1:0] dmem_addr,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                dmem_we,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [3:0]          dmem_wstrb,
  output logic                ebreak
);

  logic [`RV_XLEN-1:0] pc_plus4;
  logic                redirect;
  logic [`RV_XLEN-1:0] target;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                rd_we;
  logic [`RV_XLEN-1:0] rd_data;

  rv_dec_if dec_bus ();

  // ------------------------------
  // Fetch
  // ------------------------------
  rv_fetch fetch0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .redirect (redirect),
    .target   (target),
    .halt     (dec_bus.ctrl.ebreak),
    .pc       (imem_addr),
    .pc_plus4 (pc_plus4)
  );

  rv_decoder decoder0 (
    .instr (imem_data),
    .dec   (dec_bus.producer)
  );

  rv_regfile regfile0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .dec      (dec_bus.regs),
    .we       (rd_we),
    .wdata    (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ------------------------------
  // Execute, memory, writeback
  // ------------------------------
  rv_execute execute0 (
    .dec        (dec_bus.consumer),
    .pc         (imem_addr),
    .pc_plus4   (pc_plus4),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .redirect   (redirect),
    .target     (target),
    .rd_we      (rd_we),
    .rd_data    (rd_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_we    (dmem_we)
  );

  // High while the held PC points at EBREAK
  assign ebreak = dec_bus.ctrl.ebreak;

endmodule

`default_nettype wire

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam logic [31:0] SEED        = 32'h31cd_fd72;
  localparam logic [31:0] RES_BASE    = 32'h0000_0400;
  localparam logic [31:0] LOAD_BASE   = 32'h0000_0100;
  localparam logic [31:0] POISON_ADDR = 32'h0000_07f0;
  localparam logic [31:0] POISON      = 32'hdead_beef;
  localparam logic [31:0] MARKER      = 32'h600d_f00d;
  localparam int          RAM_WORDS   = 1024;
  localparam int          TIMEOUT     = 1000;
  localparam logic [2:0]  BR_F3 [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic                clk;
  logic                arst_n;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_data;
  logic [`RV_XLEN-1:0] dmem_addr;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                dmem_we;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic [3:0]          dmem_wstrb;
  logic                ebreak;

  logic [31:0] rom [256];
  logic [31:0] ram [RAM_WORDS];
  logic [31:0] load_word [2];
  logic [31:0] lfsr_state;
  logic [31:0] halt_pc;
  int          pc_w;
  int          slot;

  // Expected stores in program order
  logic [31:0] exp_addr [128];
  logic [31:0] exp_data [128];
  logic [3:0]  exp_strb [128];
  string       exp_tag [128];
  int          n_exp = 0;
  int          store_idx = 0;
  int          store_checks = 0;
  int          store_errs = 0;
  int          ctrl_errs = 0;

  rv_core dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .ebreak     (ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // Memory models
  // ------------------------------
  assign imem_data  = rom[imem_addr[9:2]];
  assign dmem_rdata = ram[dmem_addr[11:2]];

  function automatic logic [31:0] ram_init(input int i);
    if (i * 4 == LOAD_BASE) return load_word[0];
    if (i * 4 == LOAD_BASE + 32'd4) return load_word[1];
    return {i[15:0] ^ 16'hc3a5, ~i[15:0]};
  endfunction

  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        ram[i] <= ram_init(i);
      end
    end else if (dmem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          ram[dmem_addr[11:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[31]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic emit(input logic [31:0] ins);
    rom[pc_w] = ins;
    pc_w++;
  endtask

  // LUI plus ADDI with the upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    emit(u_type(v[31:12] + {19'b0, v[11]}, rd, OP_LUI));
    emit(i_type(v[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  task automatic check_store(input logic [2:0] f3, input logic [4:0] rs, input logic [1:0] off,
                             input logic [31:0] data, input logic [3:0] strb, input string tag);
    logic [31:0] addr;
    addr = RES_BASE + slot * 4 + {30'b0, off};
    emit(s_type(addr[11:0], rs, 5'd0, f3));
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = data;
    exp_strb[n_exp] = strb;
    exp_tag[n_exp]  = tag;
    n_exp++;
    slot++;
  endtask

  task automatic poison_store();
    emit(s_type(POISON_ADDR[11:0], 5'd6, 5'd0, 3'b010));
  endtask

  task automatic alu_reg_case(input logic [2:0] f3, input logic alt, input logic [31:0] expv,
                              input string tag);
    emit(r_type({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3));
    check_store(3'b010, 5'd3, 2'd0, expv, 4'b1111, tag);
  endtask

  task automatic alu_imm_case(input logic [2:0] f3, input logic [11:0] imm,
                              input logic [31:0] expv, input string tag);
    emit(i_type(imm, 5'd1, f3, 5'd3, OP_IMM));
    check_store(3'b010, 5'd3, 2'd0, expv, 4'b1111, tag);
  endtask

  // Taken jumps over a poison store and not taken falls into a marker store
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] va, input logic [31:0] vb);
    emit(b_type(13'd8, rs2, rs1, f3));
    if (branch_ref(f3, va, vb)) begin
      poison_store();
    end else begin
      check_store(3'b010, 5'd7, 2'd0, MARKER, 4'b1111, "branch fall-through");
    end
  endtask

  task automatic load_case(input int w, input int k, input logic [2:0] f3,
                           input logic [31:0] expv, input string tag);
    logic [31:0] addr;
    addr = LOAD_BASE + w * 4 + k;
    emit(i_type(addr[11:0], 5'd0, f3, 5'd12, OP_LOAD));
    check_store(3'b010, 5'd12, 2'd0, expv, 4'b1111, tag);
  endtask

  // ------------------------------
  // Program
  // ------------------------------
  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] simm;
    logic [31:0] p;
    logic [11:0] imm;
    logic [4:0]  sh;
    logic [7:0]  bt;
    logic [15:0] hw;
    // Background of NOPs whose immediate is the word index
    for (int i = 0; i < 256; i++) begin
      rom[i] = `RV_NOP | {i[11:0], 20'b0};
    end
    pc_w = 0;
    slot = 0;
    a = rand_bits(32);
    b = rand_bits(32);
    r = rand_bits(12);
    imm = r[11:0];
    simm = {{20{imm[11]}}, imm};
    r = rand_bits(5);
    sh = r[4:0];
    load_word[0] = rand_bits(32) & 32'h7f7f_7f7f;
    load_word[1] = rand_bits(32) | 32'h8080_8080;

    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd6, POISON);
    load_const(5'd7, MARKER);

    alu_reg_case(3'b000, 1'b0, a + b, "add");
    alu_reg_case(3'b000, 1'b1, a - b, "sub");
    alu_reg_case(3'b001, 1'b0, a << b[4:0], "sll");
    alu_reg_case(3'b010, 1'b0, {31'b0, $signed(a) < $signed(b)}, "slt");
    alu_reg_case(3'b011, 1'b0, {31'b0, a < b}, "sltu");
    alu_reg_case(3'b100, 1'b0, a ^ b, "xor");
    alu_reg_case(3'b101, 1'b0, a >> b[4:0], "srl");
    alu_reg_case(3'b101, 1'b1, $signed(a) >>> b[4:0], "sra");
    alu_reg_case(3'b110, 1'b0, a | b, "or");
    alu_reg_case(3'b111, 1'b0, a & b, "and");

    alu_imm_case(3'b000, imm, a + simm, "addi");
    alu_imm_case(3'b010, imm, {31'b0, $signed(a) < $signed(simm)}, "slti");
    alu_imm_case(3'b011, imm, {31'b0, a < simm}, "sltiu");
    alu_imm_case(3'b100, imm, a ^ simm, "xori");
    alu_imm_case(3'b110, imm, a | simm, "ori");
    alu_imm_case(3'b111, imm, a & simm, "andi");
    alu_imm_case(3'b001, {7'b0, sh}, a << sh, "slli");
    alu_imm_case(3'b101, {7'b0, sh}, a >> sh, "srli");
    alu_imm_case(3'b101, {7'b0100000, sh}, $signed(a) >>> sh, "srai");

    emit(u_type(b[19:0], 5'd4, OP_LUI));
    check_store(3'b010, 5'd4, 2'd0, {b[19:0], 12'b0}, 4'b1111, "lui");
    p = pc_w * 4;
    emit(u_type(a[19:0], 5'd4, OP_AUIPC));
    check_store(3'b010, 5'd4, 2'd0, p + {a[19:0], 12'b0}, 4'b1111, "auipc");

    for (int i = 0; i < 6; i++) begin
      branch_case(BR_F3[i], 5'd1, 5'd2, a, b);
      branch_case(BR_F3[i], 5'd2, 5'd1, b, a);
      branch_case(BR_F3[i], 5'd1, 5'd1, a, a);
    end

    p = pc_w * 4;
    emit(j_type(21'd8, 5'd8));
    poison_store();
    check_store(3'b010, 5'd8, 2'd0, p + 32'd4, 4'b1111, "jal link");
    // Offset 13 lands on the store once bit 0 is cleared
    p = pc_w * 4;
    emit(u_type(20'd0, 5'd9, OP_AUIPC));
    emit(i_type(12'd13, 5'd9, 3'b000, 5'd10, OP_JALR));
    poison_store();
    check_store(3'b010, 5'd10, 2'd0, p + 32'd8, 4'b1111, "jalr link");

    load_const(5'd11, b ^ a);
    r = b ^ a;
    check_store(3'b000, 5'd11, 2'd0, {4{r[7:0]}}, 4'b0001, "sb lane 0");
    check_store(3'b000, 5'd11, 2'd1, {4{r[7:0]}}, 4'b0010, "sb lane 1");
    check_store(3'b000, 5'd11, 2'd2, {4{r[7:0]}}, 4'b0100, "sb lane 2");
    check_store(3'b000, 5'd11, 2'd3, {4{r[7:0]}}, 4'b1000, "sb lane 3");
    check_store(3'b001, 5'd11, 2'd0, {2{r[15:0]}}, 4'b0011, "sh low");
    check_store(3'b001, 5'd11, 2'd2, {2{r[15:0]}}, 4'b1100, "sh high");

    for (int w = 0; w < 2; w++) begin
      for (int k = 0; k < 4; k++) begin
        bt = load_word[w][8*k +: 8];
        load_case(w, k, 3'b000, {{24{bt[7]}}, bt}, "lb");
        load_case(w, k, 3'b100, {24'b0, bt}, "lbu");
      end
      for (int k = 0; k < 4; k += 2) begin
        hw = load_word[w][8*k +: 16];
        load_case(w, k, 3'b001, {{16{hw[15]}}, hw}, "lh");
        load_case(w, k, 3'b101, {16'b0, hw}, "lhu");
      end
      load_case(w, 0, 3'b010, load_word[w], "lw");
    end

    halt_pc = pc_w * 4;
    emit({12'h001, 5'd0, 3'd0, 5'd0, OP_SYSTEM});
  endtask

  // ------------------------------
  // Store checker
  // ------------------------------
  always @(negedge clk) begin : store_check
    logic [31:0] mask;
    if (arst_n && dmem_we) begin
      store_checks++;
      assert (dmem_addr != POISON_ADDR && dmem_wdata != POISON) else begin
        store_errs++;
        $display("[ERROR] %0t: poison store, addr %h data %h", $time, dmem_addr, dmem_wdata);
      end
      assert (store_idx < n_exp) else begin
        store_errs++;
        $display("Store to %h came after all expected stores were seen", dmem_addr);
      end
      if (store_idx < n_exp && dmem_addr != POISON_ADDR) begin
        mask = lane_mask(exp_strb[store_idx]);
        assert (dmem_addr == exp_addr[store_idx]) else begin
          store_errs++;
          $display("[ERROR] %0t: %s addr %h, expected %h", $time, exp_tag[store_idx],
                   dmem_addr, exp_addr[store_idx]);
        end
        assert (dmem_wstrb == exp_strb[store_idx]) else begin
          store_errs++;
          $display("[ERROR] %0t: %s strobes %b, expected %b", $time, exp_tag[store_idx],
                   dmem_wstrb, exp_strb[store_idx]);
        end
        assert ((dmem_wdata & mask) == (exp_data[store_idx] & mask)) else begin
          store_errs++;
          $display("[ERROR] %0t: %s data %h, expected %h", $time, exp_tag[store_idx],
                   dmem_wdata & mask, exp_data[store_idx] & mask);
        end
        store_idx++;
      end
    end else if (arst_n) begin
      // No lane may be enabled outside a store
      assert (dmem_wstrb == 4'b0000) else begin
        store_errs++;
        $display("[ERROR] %0t: strobes %b without a store, expected 0000", $time,
                 dmem_wstrb);
      end
    end
  end

  // ------------------------------
  // Reset, run and report
  // ------------------------------
  initial begin
    int          cyc;
    logic [31:0] halt_addr;
    arst_n <= 1'b0;
    lfsr_state = SEED;
    build_program();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (imem_addr == `RV_RESET_PC) else begin
      ctrl_errs++;
      $display("[ERROR] %0t: first fetch at %h, expected %h", $time, imem_addr, `RV_RESET_PC);
    end

    cyc = 0;
    while (!ebreak && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end

    if (!ebreak) begin
      ctrl_errs++;
      $display("Timeout: ebreak did not rise within %0d cycles", TIMEOUT);
    end else begin
      assert (imem_addr == halt_pc) else begin
        ctrl_errs++;
        $display("[ERROR] %0t: halted at %h, expected %h", $time, imem_addr, halt_pc);
      end
      halt_addr = imem_addr;
      repeat (5) begin
        @(negedge clk);
        assert (ebreak && imem_addr == halt_addr) else begin
          ctrl_errs++;
          $display("[ERROR] %0t: PC %h ebreak %b after halt at %h", $time, imem_addr,
                   ebreak, halt_addr);
        end
      end
      assert (store_idx == n_exp) else begin
        ctrl_errs++;
        $display("[ERROR] %0t: %0d expected stores seen, %0d expected", $time, store_idx,
                 n_exp);
      end
    end

    $display("Stores checked: %0d, store errors: %0d, control errors: %0d",
             store_checks, store_errs, ctrl_errs);
    if (store_errs == 0 && ctrl_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_dec_if.sv
verilog/rv_fetch.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_mem_fmt.sv
verilog/rv_execute.sv
verilog/rv_core.sv
dv/tb_rv_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
